// ==== list.f ====
common/playseq_pkg.sv
rtl/sequence_rom.sv
rtl/round_tracker.sv
rtl/play_timer.sv
rtl/score_keeper.sv
control/playseq_control.sv
rtl/playseq_top.sv
dv/playseq_tb.sv

// ==== Bender.yml ====
package:
  name: playseq

sources:
  # Shared package
  - common/playseq_pkg.sv
  # Datapath blocks
  - rtl/sequence_rom.sv
  - rtl/round_tracker.sv
  - rtl/play_timer.sv
  - rtl/score_keeper.sv
  # Controller
  - control/playseq_control.sv
  # Top level
  - rtl/playseq_top.sv
  # Testbench
  - target: simulation
    files:
      - dv/playseq_tb.sv

// ==== dv/playseq_tb.sv ====
`timescale 1ns/10ps

module playseq_tb;
    import playseq_pkg::*;

    localparam int   NUM_ROWS      = 8;
    localparam int   NUM_PASSES    = 4;
    localparam int   GAME_BOUND    = 4000;
    localparam int   PREVIEW_LIMIT = SEQ_DEPTH * (PREVIEW_TICKS + GAP_TICKS) + 8;
    localparam logic KIND_WRONG    = 1'b0;
    localparam logic KIND_TIMEOUT  = 1'b1;
    localparam longint WATCHDOG_NS = longint'(NUM_PASSES * NUM_ROWS + 1) * GAME_BOUND * 40;

    typedef struct packed {
        logic [1:0] bank;
        logic [1:0] level;
        logic       ign;
        logic [4:0] fail_round;
        logic       kind;
        logic       exp_win;
    } row_t;

    logic       clock;
    logic       rst_n;
    logic       jogar;
    logic [1:0] memoria;
    logic [1:0] nivel;
    logic       ignora_timeout;
    move_req_t  move;
    logic       play_ready;
    logic       ganhou;
    logic       perdeu;
    logic [3:0] leds;
    logic [6:0] vitorias;
    logic [6:0] derrotas;

    int errors = 0;
    int wins   = 0;
    int losses = 0;
    int games  = 0;

    // Segments gfedcba for 0 to F
    logic [6:0] seg_hex [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                                 7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

    // bank, level, ignore timeout, fail round, fail kind, expect win
    row_t rows [NUM_ROWS] = '{
        '{2'd0, 2'd0, 1'b0, 5'd0, KIND_WRONG,   1'b1},
        '{2'd1, 2'd1, 1'b0, 5'd0, KIND_WRONG,   1'b1},
        '{2'd2, 2'd2, 1'b0, 5'd0, KIND_WRONG,   1'b1},
        '{2'd3, 2'd3, 1'b0, 5'd0, KIND_WRONG,   1'b1},
        '{2'd1, 2'd2, 1'b0, 5'd3, KIND_WRONG,   1'b0},
        '{2'd2, 2'd1, 1'b0, 5'd2, KIND_TIMEOUT, 1'b0},
        '{2'd3, 2'd0, 1'b1, 5'd2, KIND_TIMEOUT, 1'b1},
        '{2'd0, 2'd3, 1'b0, 5'd1, KIND_WRONG,   1'b0}
    };

    playseq_top DUT (
        .clock          ( clock          ),
        .rst_n          ( rst_n          ),
        .jogar          ( jogar          ),
        .memoria        ( memoria        ),
        .nivel          ( nivel          ),
        .ignora_timeout ( ignora_timeout ),
        .move           ( move           ),
        .play_ready     ( play_ready     ),
        .ganhou         ( ganhou         ),
        .perdeu         ( perdeu         ),
        .leds           ( leds           ),
        .vitorias       ( vitorias       ),
        .derrotas       ( derrotas       )
    );

    always #20 clock = ~clock;

    // ----------------------------------------
    // Reference model and reporting
    // ----------------------------------------
    function automatic logic [3:0] expected_button(input int bank, input int k);
        int idx;
        idx = (3 * k + bank + k / 4) % 4;
        return 4'b0001 << idx;
    endfunction

    function automatic logic [3:0] rotate_button(input logic [3:0] b);
        return {b[2:0], b[3]};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[FAIL] %s: expected %0h, got %0h", name, exp, act);
        errors++;
    endtask

    // Follows one preview and may add a stray press while the leds are busy
    task automatic watch_preview(input logic [1:0] bank, input int round_len, input bit probe,
                                 output bit ok);
        int         cyc;
        int         lit_count;
        int         lit_len;
        int         dark_len;
        logic [3:0] prev_leds;
        bit         done;
        cyc       = 0;
        lit_count = 0;
        lit_len   = 0;
        dark_len  = 0;
        prev_leds = '0;
        done      = 1'b0;
        ok        = 1'b0;
        while (!done && cyc < PREVIEW_LIMIT) begin
            @(posedge clock);
            if (probe && cyc == 1) begin
                move.button <= rotate_button(expected_button(bank, 0));
                move.valid  <= 1'b1;
            end
            if (probe && cyc == 2) move.valid <= 1'b0;
            @(negedge clock);
            cyc++;
            if (ganhou || perdeu) begin
                $display("Result flag raised during the preview of round %0d", round_len);
                errors++;
            end
            if (play_ready) begin
                done = 1'b1;
                if (dark_len != GAP_TICKS) report_mismatch("gap cycles", GAP_TICKS, dark_len);
            end else if (leds != '0) begin
                if (prev_leds == '0) begin
                    if (lit_count > 0 && dark_len != GAP_TICKS)
                        report_mismatch("gap cycles", GAP_TICKS, dark_len);
                    if (lit_count < round_len && leds !== expected_button(bank, lit_count))
                        report_mismatch("leds", expected_button(bank, lit_count), leds);
                    lit_count++;
                    lit_len = 0;
                end
                lit_len++;
                dark_len = 0;
            end else begin
                if (prev_leds != '0 && lit_len != PREVIEW_TICKS)
                    report_mismatch("lit cycles", PREVIEW_TICKS, lit_len);
                dark_len++;
            end
            prev_leds = leds;
        end
        if (!done) begin
            $display("Timed out waiting for play_ready after the preview");
            errors++;
        end else begin
            if (lit_count != round_len) report_mismatch("preview moves", round_len, lit_count);
            ok = 1'b1;
        end
    endtask

    // Holds valid until the DUT takes the move and returns one cycle later
    task automatic press_move(input logic [3:0] btn, input int delay, output bit ok);
        ok = 1'b0;
        repeat (delay) @(posedge clock);
        @(posedge clock);
        move.button <= btn;
        move.valid  <= 1'b1;
        @(negedge clock);
        if (!play_ready) begin
            $display("Press was not taken because play_ready was low");
            errors++;
            @(posedge clock);
            move.valid <= 1'b0;
            return;
        end
        @(posedge clock);
        move.valid <= 1'b0;
        @(negedge clock);
        if (play_ready !== 1'b0) report_mismatch("play_ready", 0, play_ready);
        ok = 1'b1;
    endtask

    // ----------------------------------------
    // One game from a table row
    // ----------------------------------------
    task automatic play_game(input row_t row);
        int         final_len;
        int         fail_k;
        int         previews;
        int         round;
        int         k;
        int         n;
        bit         ok;
        bit         over;
        logic [3:0] exp_btn;
        logic [3:0] btn;
        final_len = 4 * (row.level + 1);
        previews  = 0;
        over      = 1'b0;
        @(posedge clock);
        jogar          <= 1'b1;
        memoria        <= row.bank;
        nivel          <= row.level;
        ignora_timeout <= row.ign;
        @(posedge clock);
        jogar <= 1'b0;
        for (round = 1; round <= final_len && !over; round++) begin
            watch_preview(row.bank, round, round == 1, ok);
            if (!ok) return;
            previews++;
            fail_k = (round == row.fail_round) ? round / 2 : -1;
            for (k = 0; k < round && !over; k++) begin
                exp_btn = expected_button(row.bank, k);
                if (k == fail_k && row.kind == KIND_TIMEOUT) begin
                    n = 0;
                    while (!perdeu && n < TIMEOUT_TICKS + 20) begin
                        @(negedge clock);
                        n++;
                    end
                    if (!row.ign) begin
                        if (n != TIMEOUT_TICKS)
                            report_mismatch("timeout cycles", TIMEOUT_TICKS, n);
                        over = 1'b1;
                    end else if (perdeu || !play_ready) begin
                        $display("Game ended on a timeout although the timeout is ignored");
                        errors++;
                        over = 1'b1;
                    end
                end
                if (!over) begin
                    btn = (k == fail_k && row.kind == KIND_WRONG) ? rotate_button(exp_btn)
                                                                  : exp_btn;
                    press_move(btn, $urandom % 8, ok);
                    if (!ok) return;
                    @(negedge clock);
                    if (btn != exp_btn || (k == round - 1 && round == final_len)) begin
                        over = 1'b1;
                    end else begin
                        if (k < round - 1 && play_ready !== 1'b1)
                            report_mismatch("play_ready", 1, play_ready);
                        if (ganhou || perdeu) begin
                            $display("Result raised in the middle of a game");
                            errors++;
                            over = 1'b1;
                        end
                    end
                end
            end
        end
        // Flag and tally are checked in the cycle the flag rises
        if (row.exp_win) begin
            wins++;
            if (ganhou !== 1'b1) report_mismatch("ganhou", 1, ganhou);
            if (perdeu !== 1'b0) report_mismatch("perdeu", 0, perdeu);
            if (previews != final_len) report_mismatch("rounds", final_len, previews);
        end else begin
            losses++;
            if (perdeu !== 1'b1) report_mismatch("perdeu", 1, perdeu);
            if (ganhou !== 1'b0) report_mismatch("ganhou", 0, ganhou);
        end
        if (vitorias !== seg_hex[wins % 16])
            report_mismatch("vitorias", seg_hex[wins % 16], vitorias);
        if (derrotas !== seg_hex[losses % 16])
            report_mismatch("derrotas", seg_hex[losses % 16], derrotas);
        games++;
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------
    initial begin
        clock          = 1'b0;
        rst_n          = 1'b0;
        jogar          = 1'b0;
        memoria        = '0;
        nivel          = '0;
        ignora_timeout = 1'b0;
        move           = '0;
        void'($urandom(32'h954f));
        repeat (16) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        if (ganhou !== 1'b0) report_mismatch("ganhou", 0, ganhou);
        if (perdeu !== 1'b0) report_mismatch("perdeu", 0, perdeu);
        if (play_ready !== 1'b0) report_mismatch("play_ready", 0, play_ready);
        if (leds !== 4'h0) report_mismatch("leds", 0, leds);
        if (vitorias !== seg_hex[0]) report_mismatch("vitorias", seg_hex[0], vitorias);
        if (derrotas !== seg_hex[0]) report_mismatch("derrotas", seg_hex[0], derrotas);
        for (int pass = 0; pass < NUM_PASSES; pass++) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                play_game(rows[r]);
            end
        end
        $display("Games: %0d, wins: %0d, losses: %0d, errors: %0d", games, wins, losses, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired because the games did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule

// ==== rtl/playseq_top.sv ====
`timescale 1ns/10ps

module playseq_top (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   jogar,
    input  logic [1:0]             memoria,
    input  logic [1:0]             nivel,
    input  logic                   ignora_timeout,
    input  playseq_pkg::move_req_t move,
    output logic                   play_ready,
    output logic                   ganhou,
    output logic                   perdeu,
    output logic [3:0]             leds,
    output logic [6:0]             vitorias,
    output logic [6:0]             derrotas
);
    import playseq_pkg::*;

    game_cfg_t              cfg;
    dp_cmd_t                cmd;
    dp_status_t             status;
    logic [ADDR_W-1:0]      addr;
    logic [NUM_BUTTONS-1:0] rom_move;
    logic                   show_led;
    logic                   addr_at_round;
    logic                   round_at_final;
    logic                   timer_done;

    assign status = '{addr_at_round: addr_at_round, round_at_final: round_at_final,
                      timer_done: timer_done};

    // ----------------------------------------
    // Controller
    // ----------------------------------------
    playseq_control u_control (
        .clock          ( clock          ),
        .rst_n          ( rst_n          ),
        .jogar          ( jogar          ),
        .memoria        ( memoria        ),
        .nivel          ( nivel          ),
        .ignora_timeout ( ignora_timeout ),
        .move           ( move           ),
        .status         ( status         ),
        .rom_move       ( rom_move       ),
        .cfg            ( cfg            ),
        .cmd            ( cmd            ),
        .play_ready     ( play_ready     ),
        .show_led       ( show_led       ),
        .ganhou         ( ganhou         ),
        .perdeu         ( perdeu         )
    );

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    sequence_rom u_rom (
        .bank ( cfg.bank ),
        .addr ( addr     ),
        .move ( rom_move )
    );

    round_tracker u_round (
        .clock          ( clock          ),
        .rst_n          ( rst_n          ),
        .cmd            ( cmd            ),
        .level          ( cfg.level      ),
        .addr           ( addr           ),
        .addr_at_round  ( addr_at_round  ),
        .round_at_final ( round_at_final )
    );

    play_timer u_timer (
        .clock      ( clock      ),
        .rst_n      ( rst_n      ),
        .cmd        ( cmd        ),
        .timer_done ( timer_done )
    );

    score_keeper u_score (
        .clock    ( clock    ),
        .rst_n    ( rst_n    ),
        .cmd      ( cmd      ),
        .vitorias ( vitorias ),
        .derrotas ( derrotas )
    );

    // Leds only during preview
    assign leds = show_led ? rom_move : '0;

endmodule

// ==== control/playseq_control.sv ====
`timescale 1ns/10ps

module playseq_control (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    jogar,
    input  logic [1:0]              memoria,
    input  logic [1:0]              nivel,
    input  logic                    ignora_timeout,
    input  playseq_pkg::move_req_t  move,
    input  playseq_pkg::dp_status_t status,
    input  logic [3:0]              rom_move,
    output playseq_pkg::game_cfg_t  cfg,
    output playseq_pkg::dp_cmd_t    cmd,
    output logic                    play_ready,
    output logic                    show_led,
    output logic                    ganhou,
    output logic                    perdeu
);
    import playseq_pkg::*;

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_preview_on,
        st_preview_gap,
        st_wait_move,
        st_check,
        st_next_round,
        st_won,
        st_lost
    } state_t;

    state_t                 state;
    state_t                 state_next;
    logic [NUM_BUTTONS-1:0] button_q;
    logic                   can_start;
    logic                   start_game;
    logic                   accept;
    logic                   move_ok;

    assign can_start  = (state == st_idle) || (state == st_won) || (state == st_lost);
    assign start_game = jogar && can_start;
    assign accept     = move.valid && play_ready;
    assign move_ok    = (button_q == rom_move);

    // ----------------------------------------
    // State and configuration
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= st_idle;
            cfg   <= '0;
        end else begin
            state <= state_next;
            if (start_game) begin
                cfg.bank  <= memoria;
                cfg.level <= nivel;
            end
        end
    end

    // Accepted button for the check state
    always_ff @(posedge clock) begin
        if (accept) begin
            button_q <= move.button;
        end
    end

    // ----------------------------------------
    // Next state and datapath commands
    // ----------------------------------------
    always_comb begin
        state_next = state;
        cmd        = '0;
        case (state)
            st_idle, st_won, st_lost: begin
                if (jogar) state_next = st_start;
            end
            st_start: begin
                cmd.clr_round   = 1'b1;
                cmd.clr_addr    = 1'b1;
                cmd.timer_start = 1'b1;
                cmd.timer_mode  = TMR_PREVIEW;
                state_next      = st_preview_on;
            end
            st_preview_on: begin
                if (status.timer_done) begin
                    cmd.timer_start = 1'b1;
                    cmd.timer_mode  = TMR_GAP;
                    state_next      = st_preview_gap;
                end
            end
            st_preview_gap: begin
                if (status.timer_done) begin
                    cmd.timer_start = 1'b1;
                    if (status.addr_at_round) begin
                        // Hand over to the player once the whole prefix is shown
                        cmd.clr_addr   = 1'b1;
                        cmd.timer_mode = TMR_TIMEOUT;
                        state_next     = st_wait_move;
                    end else begin
                        cmd.inc_addr   = 1'b1;
                        cmd.timer_mode = TMR_PREVIEW;
                        state_next     = st_preview_on;
                    end
                end
            end
            st_wait_move: begin
                if (accept) begin
                    state_next = st_check;
                end else if (status.timer_done && !ignora_timeout) begin
                    cmd.loss_pulse = 1'b1;
                    state_next     = st_lost;
                end
            end
            st_check: begin
                if (!move_ok) begin
                    cmd.loss_pulse = 1'b1;
                    state_next     = st_lost;
                end else if (!status.addr_at_round) begin
                    cmd.inc_addr    = 1'b1;
                    cmd.timer_start = 1'b1;
                    cmd.timer_mode  = TMR_TIMEOUT;
                    state_next      = st_wait_move;
                end else if (status.round_at_final) begin
                    cmd.win_pulse = 1'b1;
                    state_next    = st_won;
                end else begin
                    state_next = st_next_round;
                end
            end
            st_next_round: begin
                cmd.inc_round   = 1'b1;
                cmd.clr_addr    = 1'b1;
                cmd.timer_start = 1'b1;
                cmd.timer_mode  = TMR_PREVIEW;
                state_next      = st_preview_on;
            end
            default: state_next = st_idle;
        endcase
    end

    assign play_ready = (state == st_wait_move);
    assign show_led   = (state == st_preview_on);
    assign ganhou     = (state == st_won);
    assign perdeu     = (state == st_lost);

    // Fresh preview timer never expires on its first cycle
    assert property (@(posedge clock) disable iff (!rst_n) $rose(show_led) |-> !status.timer_done);

    // Preview lights exactly one button
    assert property (@(posedge clock) disable iff (!rst_n) show_led |-> $onehot(rom_move));

endmodule

// ==== rtl/score_keeper.sv ====
`timescale 1ns/10ps

module score_keeper (
    input  logic                 clock,
    input  logic                 rst_n,
    input  playseq_pkg::dp_cmd_t cmd,
    output logic [6:0]           vitorias,
    output logic [6:0]           derrotas
);
    import playseq_pkg::*;

    logic [3:0] wins;
    logic [3:0] losses;

    // Segments gfedcba, active high
    function automatic logic [6:0] hex_to_seg(input logic [3:0] value);
        case (value)
            4'h0:    return 7'h3F;
            4'h1:    return 7'h06;
            4'h2:    return 7'h5B;
            4'h3:    return 7'h4F;
            4'h4:    return 7'h66;
            4'h5:    return 7'h6D;
            4'h6:    return 7'h7D;
            4'h7:    return 7'h07;
            4'h8:    return 7'h7F;
            4'h9:    return 7'h6F;
            4'hA:    return 7'h77;
            4'hB:    return 7'h7C;
            4'hC:    return 7'h39;
            4'hD:    return 7'h5E;
            4'hE:    return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    // ----------------------------------------
    // Tallies, wrap after 15
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wins   <= '0;
            losses <= '0;
        end else begin
            if (cmd.win_pulse) wins <= wins + 4'd1;
            if (cmd.loss_pulse) losses <= losses + 4'd1;
        end
    end

    assign vitorias = hex_to_seg(wins);
    assign derrotas = hex_to_seg(losses);

    // A game ends one way only
    assert property (@(posedge clock) disable iff (!rst_n) !(cmd.win_pulse && cmd.loss_pulse));

endmodule

// ==== rtl/play_timer.sv ====
`timescale 1ns/10ps

module play_timer (
    input  logic                 clock,
    input  logic                 rst_n,
    input  playseq_pkg::dp_cmd_t cmd,
    output logic                 timer_done
);
    import playseq_pkg::*;

    logic [TIMER_W-1:0] count;
    logic [TIMER_W-1:0] limit;
    logic               running;

    // Last count value for each mode
    always_comb begin
        case (cmd.timer_mode)
            TMR_PREVIEW: limit = TIMER_W'(PREVIEW_TICKS - 1);
            TMR_GAP:     limit = TIMER_W'(GAP_TICKS - 1);
            default:     limit = TIMER_W'(TIMEOUT_TICKS - 1);
        endcase
    end

    // Restart has priority over expiry
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            running <= 1'b0;
        end else if (cmd.timer_start) begin
            running <= 1'b1;
        end else if (timer_done) begin
            running <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (cmd.timer_start) begin
            count <= limit;
        end else if (running && count != '0) begin
            count <= count - TIMER_W'(1);
        end
    end

    assign timer_done = running && (count == '0);

endmodule

// ==== rtl/round_tracker.sv ====
`timescale 1ns/10ps

module round_tracker (
    input  logic                 clock,
    input  logic                 rst_n,
    input  playseq_pkg::dp_cmd_t cmd,
    input  logic [1:0]           level,
    output logic [3:0]           addr,
    output logic                 addr_at_round,
    output logic                 round_at_final
);
    import playseq_pkg::*;

    // Moves in the current round, 1 to 16
    logic [ROUND_W-1:0] round_len;

    // ----------------------------------------
    // Counters
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            addr <= '0;
        end else if (cmd.clr_addr) begin
            addr <= '0;
        end else if (cmd.inc_addr) begin
            addr <= addr + 4'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            round_len <= ROUND_W'(1);
        end else if (cmd.clr_round) begin
            round_len <= ROUND_W'(1);
        end else if (cmd.inc_round) begin
            round_len <= round_len + ROUND_W'(1);
        end
    end

    // Compare flags
    assign addr_at_round  = ({1'b0, addr} == round_len - ROUND_W'(1));
    assign round_at_final = (round_len == final_round(level));

    // Address stays inside the current round
    assert property (@(posedge clock) disable iff (!rst_n) {1'b0, addr} < round_len);

endmodule

// ==== rtl/sequence_rom.sv ====
`timescale 1ns/10ps

module sequence_rom (
    input  logic [1:0] bank,
    input  logic [3:0] addr,
    output logic [3:0] move
);
    import playseq_pkg::*;

    // Flat table, bank in the upper index bits
    logic [NUM_BUTTONS-1:0] rom_table [NUM_BANKS*SEQ_DEPTH];

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        for (genvar k = 0; k < SEQ_DEPTH; k++) begin : g_move
            assign rom_table[b*SEQ_DEPTH+k] = seq_move(2'(b), ADDR_W'(k));
        end
    end

    assign move = rom_table[{bank, addr}];

endmodule

// ==== common/playseq_pkg.sv ====
package playseq_pkg;

    // ----------------------------------------
    // Game geometry
    // ----------------------------------------
    localparam int NUM_BUTTONS = 4;
    localparam int SEQ_DEPTH   = 16;
    localparam int ADDR_W      = $clog2(SEQ_DEPTH);
    localparam int ROUND_W     = ADDR_W + 1;
    localparam int NUM_BANKS   = 4;

    // Timing in clock cycles
    localparam int PREVIEW_TICKS = 8;
    localparam int GAP_TICKS     = 4;
    localparam int TIMEOUT_TICKS = 200;
    localparam int TIMER_W       = $clog2(TIMEOUT_TICKS);

    // Timer modes
    localparam logic [1:0] TMR_PREVIEW = 2'd0;
    localparam logic [1:0] TMR_GAP     = 2'd1;
    localparam logic [1:0] TMR_TIMEOUT = 2'd2;

    // ----------------------------------------
    // Types
    // ----------------------------------------
    typedef struct packed {
        logic [1:0] bank;
        logic [1:0] level;
    } game_cfg_t;

    typedef struct packed {
        logic                   valid;
        logic [NUM_BUTTONS-1:0] button;
    } move_req_t;

    // Control to datapath
    typedef struct packed {
        logic       clr_round;
        logic       inc_round;
        logic       clr_addr;
        logic       inc_addr;
        logic       timer_start;
        logic [1:0] timer_mode;
        logic       win_pulse;
        logic       loss_pulse;
    } dp_cmd_t;

    // Datapath to control
    typedef struct packed {
        logic addr_at_round;
        logic round_at_final;
        logic timer_done;
    } dp_status_t;

    // Move k of bank b lights button (3k + b + k/4) mod 4
    function automatic logic [NUM_BUTTONS-1:0] seq_move(input logic [1:0] bank,
                                                          input logic [ADDR_W-1:0] k);
        int unsigned idx;
        idx = (3 * k + bank + k / 4) % NUM_BUTTONS;
        return NUM_BUTTONS'(1) << idx;
    endfunction

    // Rounds to win: 4, 8, 12 or 16
    function automatic logic [ROUND_W-1:0] final_round(input logic [1:0] level);
        return ROUND_W'({level, 2'b00}) + ROUND_W'(4);
    endfunction

endpackage
